//--- source/exu_params.svh
`ifndef EXU_PARAMS_SVH
`define EXU_PARAMS_SVH

`define EXU_XLEN        32
`define EXU_MTVEC_RESET 32'h0000_0100

// rv32 base opcodes
`define EXU_OP_JAL    7'b1101111
`define EXU_OP_JALR   7'b1100111
`define EXU_OP_BRANCH 7'b1100011
`define EXU_OP_LOAD   7'b0000011
`define EXU_OP_STORE  7'b0100011
`define EXU_OP_SYSTEM 7'b1110011

// alu op codes
`define EXU_ALU_ADD  4'd0
`define EXU_ALU_SUB  4'd1
`define EXU_ALU_AND  4'd2
`define EXU_ALU_OR   4'd3
`define EXU_ALU_XOR  4'd4
`define EXU_ALU_SLL  4'd5
`define EXU_ALU_SRL  4'd6
`define EXU_ALU_SRA  4'd7
`define EXU_ALU_SLT  4'd8
`define EXU_ALU_SLTU 4'd9
`define EXU_ALU_SLE  4'd10
`define EXU_ALU_SLEU 4'd11

// system function codes, carried in imm
`define EXU_SYS_ECALL 12'h000
`define EXU_SYS_MRET  12'h302

// low two bits of func3 for the csr forms, same for the imm variants
`define EXU_CSR_F_RW 2'b01
`define EXU_CSR_F_RS 2'b10
`define EXU_CSR_F_RC 2'b11

`define EXU_CSR_MSTATUS 12'h300
`define EXU_CSR_MTVEC   12'h305
`define EXU_CSR_MEPC    12'h341
`define EXU_CSR_MCAUSE  12'h342

`define EXU_CAUSE_ECALL_M 32'd11

`endif

//--- source/exu_pkg.sv
`include "exu_params.svh"

package exu_pkg;

  typedef enum logic [3:0] {
    ALU_ADD  = `EXU_ALU_ADD,
    ALU_SUB  = `EXU_ALU_SUB,
    ALU_AND  = `EXU_ALU_AND,
    ALU_OR   = `EXU_ALU_OR,
    ALU_XOR  = `EXU_ALU_XOR,
    ALU_SLL  = `EXU_ALU_SLL,
    ALU_SRL  = `EXU_ALU_SRL,
    ALU_SRA  = `EXU_ALU_SRA,
    ALU_SLT  = `EXU_ALU_SLT,
    ALU_SLTU = `EXU_ALU_SLTU,
    ALU_SLE  = `EXU_ALU_SLE,
    ALU_SLEU = `EXU_ALU_SLEU
  } alu_op_e;

  // decoded instruction from the previous stage
  typedef struct packed {
    logic [6:0]           opcode;
    logic [2:0]           func3;
    logic [`EXU_XLEN-1:0] pc;
    logic [`EXU_XLEN-1:0] src1;
    logic [`EXU_XLEN-1:0] src2;
    logic [`EXU_XLEN-1:0] jbase;
    logic [`EXU_XLEN-1:0] imm;
    alu_op_e              alu_op;
    logic [3:0]           rd;
    logic                 load;
    logic                 store;
    logic                 csr_op;
    // ecall/mret group, function code sits in imm
    logic                 sys_func;
    logic                 ebreak;
  } exu_issue_t;

  typedef struct packed {
    logic [3:0]           rd;
    logic [`EXU_XLEN-1:0] wdata;
    logic [`EXU_XLEN-1:0] npc;
    logic                 redirect;
    logic                 branch_retire;
    logic                 ebreak;
  } exu_commit_t;

  typedef struct packed {
    logic [`EXU_XLEN-1:0] addr;
    logic [`EXU_XLEN-1:0] wdata;
    logic                 write;
  } mem_req_t;

  typedef struct packed {
    logic [11:0]          addr;
    logic [`EXU_XLEN-1:0] wdata;
    logic                 wen;
    logic                 ecall;
    logic                 mret;
    logic [`EXU_XLEN-1:0] pc;
  } csr_cmd_t;

endpackage

//--- source/exu_alu.sv
`timescale 1ns/1ps
`include "exu_params.svh"

module exu_alu (
  input  logic [`EXU_XLEN-1:0] a_i,
  input  logic [`EXU_XLEN-1:0] b_i,
  input  exu_pkg::alu_op_e     op_i,
  output logic [`EXU_XLEN-1:0] res_o
);

  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;
  logic       eq;

  assign shamt = b_i[4:0];
  assign lt_s  = $signed(a_i) < $signed(b_i);
  assign lt_u  = a_i < b_i;
  assign eq    = a_i == b_i;

  always_comb begin
    case (op_i)
      exu_pkg::ALU_ADD: begin
        res_o = a_i + b_i;
      end
      exu_pkg::ALU_SUB: begin
        res_o = a_i - b_i;
      end
      exu_pkg::ALU_AND: begin
        res_o = a_i & b_i;
      end
      exu_pkg::ALU_OR: begin
        res_o = a_i | b_i;
      end
      exu_pkg::ALU_XOR: begin
        res_o = a_i ^ b_i;
      end
      exu_pkg::ALU_SLL: begin
        res_o = a_i << shamt;
      end
      exu_pkg::ALU_SRL: begin
        res_o = a_i >> shamt;
      end
      exu_pkg::ALU_SRA: begin
        res_o = $unsigned($signed(a_i) >>> shamt);
      end
      // compares give a single bit
      exu_pkg::ALU_SLT: begin
        res_o = {{(`EXU_XLEN-1){1'b0}}, lt_s};
      end
      exu_pkg::ALU_SLTU: begin
        res_o = {{(`EXU_XLEN-1){1'b0}}, lt_u};
      end
      exu_pkg::ALU_SLE: begin
        res_o = {{(`EXU_XLEN-1){1'b0}}, lt_s | eq};
      end
      exu_pkg::ALU_SLEU: begin
        res_o = {{(`EXU_XLEN-1){1'b0}}, lt_u | eq};
      end
      default: begin
        res_o = '0;
      end
    endcase
  end

endmodule

//--- source/exu_csr_file.sv
`timescale 1ns/1ps
`include "exu_params.svh"

module exu_csr_file (
  input  logic                 clk,
  input  logic                 rst,
  input  exu_pkg::csr_cmd_t    cmd_i,
  input  logic                 commit_i,
  output logic [`EXU_XLEN-1:0] rdata_o,
  output logic [`EXU_XLEN-1:0] mtvec_o,
  output logic [`EXU_XLEN-1:0] mepc_o
);

  logic [`EXU_XLEN-1:0] mstatus_q;
  logic [`EXU_XLEN-1:0] mtvec_q;
  logic [`EXU_XLEN-1:0] mepc_q;
  logic [`EXU_XLEN-1:0] mcause_q;
  logic [`EXU_XLEN-1:0] mstatus_wr;

  // mret sets mpie on top of the old word
  assign mstatus_wr = cmd_i.mret ? {cmd_i.wdata[`EXU_XLEN-1:8], 1'b1, cmd_i.wdata[6:0]}
                                 : cmd_i.wdata;

  always_comb begin
    case (cmd_i.addr)
      `EXU_CSR_MSTATUS: rdata_o = mstatus_q;
      `EXU_CSR_MTVEC:   rdata_o = mtvec_q;
      `EXU_CSR_MEPC:    rdata_o = mepc_q;
      `EXU_CSR_MCAUSE:  rdata_o = mcause_q;
      default:          rdata_o = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus_q <= '0;
      mtvec_q   <= `EXU_MTVEC_RESET;
      mepc_q    <= '0;
      mcause_q  <= '0;
    end else if (commit_i) begin
      if (cmd_i.wen) begin
        case (cmd_i.addr)
          `EXU_CSR_MSTATUS: mstatus_q <= mstatus_wr;
          `EXU_CSR_MTVEC:   mtvec_q   <= cmd_i.wdata;
          `EXU_CSR_MEPC:    mepc_q    <= cmd_i.wdata;
          `EXU_CSR_MCAUSE:  mcause_q  <= cmd_i.wdata;
          default: ;
        endcase
      end
      // trap entry side update
      if (cmd_i.ecall) begin
        mepc_q   <= cmd_i.pc;
        mcause_q <= `EXU_CAUSE_ECALL_M;
      end
    end
  end

  assign mtvec_o = mtvec_q;
  assign mepc_o  = mepc_q;

  a_ecall_mret_exclusive : assert property (
    @(posedge clk) disable iff (rst) commit_i |-> !(cmd_i.ecall && cmd_i.mret)
  );

endmodule

//--- source/exu_stage.sv
`timescale 1ns/1ps
`include "exu_params.svh"

module exu_stage (
  input  logic                 clk,
  input  logic                 rst,
  input  exu_pkg::exu_issue_t  issue_i,
  input  logic                 prev_valid_i,
  output logic                 ready_o,
  output exu_pkg::exu_commit_t commit_o,
  output logic                 valid_o,
  input  logic                 next_ready_i,
  output exu_pkg::mem_req_t    mem_req_o,
  output logic                 mem_avalid_o,
  input  logic [`EXU_XLEN-1:0] mem_rdata_i,
  input  logic                 mem_rvalid_i,
  input  logic                 mem_wready_i,
  output exu_pkg::csr_cmd_t    csr_cmd_o,
  output logic                 csr_commit_o,
  input  logic [`EXU_XLEN-1:0] csr_rdata_i,
  input  logic [`EXU_XLEN-1:0] mtvec_i,
  input  logic [`EXU_XLEN-1:0] mepc_i
);

  exu_pkg::exu_issue_t  ins_q;
  logic [`EXU_XLEN-1:0] addr_q;
  logic [`EXU_XLEN-1:0] target_q;
  logic [`EXU_XLEN-1:0] load_data_q;
  logic [`EXU_XLEN-1:0] alu_res;
  logic [`EXU_XLEN-1:0] csr_wdata;
  logic                 valid_q;
  logic                 avalid_q;
  logic                 accept;
  logic                 retire;
  logic                 issue_mem;
  logic                 mem_resp;
  logic                 is_ecall;
  logic                 is_mret;
  logic                 redirect;

  // full when a result waits or an access is open
  assign ready_o   = !avalid_q && (!valid_q || next_ready_i);
  assign accept    = prev_valid_i && ready_o;
  assign retire    = valid_q && next_ready_i;
  assign issue_mem = issue_i.load || issue_i.store;
  assign mem_resp  = avalid_q && (ins_q.load ? mem_rvalid_i : mem_wready_i);

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q  <= 1'b0;
      avalid_q <= 1'b0;
    end else begin
      if (retire) begin
        valid_q <= 1'b0;
      end
      if (mem_resp) begin
        avalid_q <= 1'b0;
        valid_q  <= 1'b1;
      end
      // accept wins over retire on the same edge
      if (accept) begin
        valid_q  <= !issue_mem;
        avalid_q <= issue_mem;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      ins_q    <= issue_i;
      addr_q   <= issue_i.src1 + issue_i.imm;
      target_q <= issue_i.jbase + issue_i.imm;
    end
    if (mem_resp && ins_q.load) begin
      load_data_q <= mem_rdata_i;
    end
  end

  exu_alu u_alu (
    .a_i   (ins_q.src1),
    .b_i   (ins_q.src2),
    .op_i  (ins_q.alu_op),
    .res_o (alu_res)
  );

  assign is_ecall = (ins_q.opcode == `EXU_OP_SYSTEM) && ins_q.sys_func &&
                    (ins_q.imm[11:0] == `EXU_SYS_ECALL);
  assign is_mret  = (ins_q.opcode == `EXU_OP_SYSTEM) && ins_q.sys_func &&
                    (ins_q.imm[11:0] == `EXU_SYS_MRET);

  always_comb begin
    case (ins_q.opcode)
      `EXU_OP_JAL, `EXU_OP_JALR: redirect = 1'b1;
      `EXU_OP_SYSTEM:            redirect = is_ecall || is_mret;
      `EXU_OP_BRANCH: begin
        // beq via sub, bne via xor, the rest via compares
        case (ins_q.alu_op)
          exu_pkg::ALU_SUB: redirect = (alu_res == '0);
          exu_pkg::ALU_XOR, exu_pkg::ALU_SLT, exu_pkg::ALU_SLTU,
          exu_pkg::ALU_SLE, exu_pkg::ALU_SLEU: redirect = (alu_res != '0);
          default: redirect = 1'b0;
        endcase
      end
      default: redirect = 1'b0;
    endcase
  end

  always_comb begin
    if (is_mret) begin
      csr_wdata = csr_rdata_i;
    end else begin
      case (ins_q.func3[1:0])
        `EXU_CSR_F_RW: csr_wdata = ins_q.src1;
        `EXU_CSR_F_RS: csr_wdata = csr_rdata_i | ins_q.src1;
        `EXU_CSR_F_RC: csr_wdata = csr_rdata_i & ~ins_q.src1;
        default:       csr_wdata = csr_rdata_i;
      endcase
    end
  end

  always_comb begin
    csr_cmd_o.addr  = is_mret ? `EXU_CSR_MSTATUS : ins_q.imm[11:0];
    csr_cmd_o.wdata = csr_wdata;
    csr_cmd_o.wen   = ins_q.csr_op || is_mret;
    csr_cmd_o.ecall = is_ecall;
    csr_cmd_o.mret  = is_mret;
    csr_cmd_o.pc    = ins_q.pc;
  end

  assign csr_commit_o = retire;

  always_comb begin
    commit_o.rd = ins_q.rd;
    if (ins_q.rd == 4'd0) begin
      commit_o.wdata = '0;
    end else if (ins_q.load) begin
      commit_o.wdata = load_data_q;
    end else if (ins_q.csr_op) begin
      commit_o.wdata = csr_rdata_i;
    end else begin
      commit_o.wdata = alu_res;
    end
    commit_o.npc           = is_ecall ? mtvec_i : (is_mret ? mepc_i : target_q);
    commit_o.redirect      = redirect;
    commit_o.branch_retire = (ins_q.opcode == `EXU_OP_SYSTEM) ||
                             (ins_q.opcode == `EXU_OP_BRANCH) ||
                             (ins_q.opcode == `EXU_OP_LOAD);
    commit_o.ebreak        = ins_q.ebreak;
  end

  assign valid_o         = valid_q;
  assign mem_avalid_o    = avalid_q;
  assign mem_req_o.addr  = addr_q;
  assign mem_req_o.wdata = ins_q.src2;
  assign mem_req_o.write = ins_q.store;

  a_mem_req_stable : assert property (
    @(posedge clk) disable iff (rst)
    (mem_avalid_o && !mem_resp) |=> (mem_avalid_o && $stable(mem_req_o))
  );

  // csr state only moves on a handshake, so csr reads hold too
  a_commit_stable : assert property (
    @(posedge clk) disable iff (rst)
    (valid_o && !next_ready_i) |=> (valid_o && $stable(commit_o))
  );

endmodule

//--- source/exu_top.sv
`timescale 1ns/1ps
`include "exu_params.svh"

module exu_top (
  input  logic                 clk,
  input  logic                 rst,
  input  exu_pkg::exu_issue_t  issue_i,
  input  logic                 prev_valid_i,
  output logic                 ready_o,
  output exu_pkg::exu_commit_t commit_o,
  output logic                 valid_o,
  input  logic                 next_ready_i,
  output exu_pkg::mem_req_t    mem_req_o,
  output logic                 mem_avalid_o,
  input  logic [`EXU_XLEN-1:0] mem_rdata_i,
  input  logic                 mem_rvalid_i,
  input  logic                 mem_wready_i
);

  exu_pkg::csr_cmd_t    csr_cmd;
  logic                 csr_commit;
  logic [`EXU_XLEN-1:0] csr_rdata;
  logic [`EXU_XLEN-1:0] mtvec;
  logic [`EXU_XLEN-1:0] mepc;

  exu_stage u_stage (
    .clk          (clk),
    .rst          (rst),
    .issue_i      (issue_i),
    .prev_valid_i (prev_valid_i),
    .ready_o      (ready_o),
    .commit_o     (commit_o),
    .valid_o      (valid_o),
    .next_ready_i (next_ready_i),
    .mem_req_o    (mem_req_o),
    .mem_avalid_o (mem_avalid_o),
    .mem_rdata_i  (mem_rdata_i),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_wready_i (mem_wready_i),
    .csr_cmd_o    (csr_cmd),
    .csr_commit_o (csr_commit),
    .csr_rdata_i  (csr_rdata),
    .mtvec_i      (mtvec),
    .mepc_i       (mepc)
  );

  exu_csr_file u_csr (
    .clk      (clk),
    .rst      (rst),
    .cmd_i    (csr_cmd),
    .commit_i (csr_commit),
    .rdata_o  (csr_rdata),
    .mtvec_o  (mtvec),
    .mepc_o   (mepc)
  );

endmodule

//--- verification/exu_tb.sv
`timescale 1ns/1ps
`include "exu_params.svh"

module exu_tb;

  localparam int NUM_TESTS       = 5;
  localparam int CYCLES_PER_TEST = 400;

  logic                 clk = 1'b0;
  logic                 rst;
  exu_pkg::exu_issue_t  issue_i;
  logic                 prev_valid_i;
  logic                 ready_o;
  exu_pkg::exu_commit_t commit_o;
  logic                 valid_o;
  logic                 next_ready_i;
  exu_pkg::mem_req_t    mem_req_o;
  logic                 mem_avalid_o;
  logic [`EXU_XLEN-1:0] mem_rdata_i;
  logic                 mem_rvalid_i;
  logic                 mem_wready_i;

  exu_pkg::exu_commit_t exp_q[$];
  exu_pkg::exu_commit_t exp_head;
  logic                 exp_avail;
  logic [`EXU_XLEN-1:0] mem [256];
  logic [`EXU_XLEN-1:0] ref_mem [256];
  logic                 mem_busy;
  int                   mem_wait;
  logic [`EXU_XLEN-1:0] sh_mstatus;
  logic [`EXU_XLEN-1:0] sh_mtvec;
  logic [`EXU_XLEN-1:0] sh_mepc;
  logic [`EXU_XLEN-1:0] sh_mcause;
  int                   issued;
  int                   commits;
  int                   errors;
  int                   tests_run;
  int                   test_issued;
  int                   test_commits;
  int                   test_errors;

  exu_top dut (
    .clk          (clk),
    .rst          (rst),
    .issue_i      (issue_i),
    .prev_valid_i (prev_valid_i),
    .ready_o      (ready_o),
    .commit_o     (commit_o),
    .valid_o      (valid_o),
    .next_ready_i (next_ready_i),
    .mem_req_o    (mem_req_o),
    .mem_avalid_o (mem_avalid_o),
    .mem_rdata_i  (mem_rdata_i),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_wready_i (mem_wready_i)
  );

  always #4 clk = ~clk;

  // random back-pressure from the next stage
  always @(negedge clk) begin
    next_ready_i = ($urandom_range(3, 0) != 0);
  end

  // word memory, answers after 0 to 5 cycles
  always @(negedge clk) begin
    mem_rvalid_i = 1'b0;
    mem_wready_i = 1'b0;
    if (mem_avalid_o) begin
      if (!mem_busy) begin
        mem_busy = 1'b1;
        mem_wait = $urandom_range(5, 0);
      end
      if (mem_wait == 0) begin
        mem_busy = 1'b0;
        if (mem_req_o.write) begin
          mem[mem_req_o.addr[9:2]] = mem_req_o.wdata;
          mem_wready_i = 1'b1;
        end else begin
          mem_rdata_i  = mem[mem_req_o.addr[9:2]];
          mem_rvalid_i = 1'b1;
        end
      end else begin
        mem_wait--;
      end
    end
  end

  always @(negedge clk) begin
    exp_avail = (exp_q.size() != 0);
    if (exp_avail) begin
      exp_head = exp_q[0];
    end
  end

  always @(posedge clk) begin
    if (!rst && valid_o && next_ready_i) begin
      commits++;
      if (exp_q.size() != 0) begin
        void'(exp_q.pop_front());
      end
    end
  end

  a_commit_expected : assert property (
    @(posedge clk) disable iff (rst) (valid_o && next_ready_i) |-> exp_avail
  ) else begin
    errors++;
    $display("commit handshake seen with no instruction outstanding");
  end

  a_rd : assert property (
    @(posedge clk) disable iff (rst) (valid_o && next_ready_i) |-> commit_o.rd == exp_head.rd
  ) else begin
    errors++;
    $display("CHECK FAILED commit_o.rd got %h expected %h", $sampled(commit_o.rd), exp_head.rd);
  end

  a_wdata : assert property (
    @(posedge clk) disable iff (rst)
    (valid_o && next_ready_i) |-> commit_o.wdata == exp_head.wdata
  ) else begin
    errors++;
    $display("CHECK FAILED commit_o.wdata got %h expected %h",
             $sampled(commit_o.wdata), exp_head.wdata);
  end

  a_npc : assert property (
    @(posedge clk) disable iff (rst) (valid_o && next_ready_i) |-> commit_o.npc == exp_head.npc
  ) else begin
    errors++;
    $display("CHECK FAILED commit_o.npc got %h expected %h", $sampled(commit_o.npc), exp_head.npc);
  end

  a_redirect : assert property (
    @(posedge clk) disable iff (rst)
    (valid_o && next_ready_i) |-> commit_o.redirect == exp_head.redirect
  ) else begin
    errors++;
    $display("CHECK FAILED commit_o.redirect got %h expected %h",
             $sampled(commit_o.redirect), exp_head.redirect);
  end

  a_branch_retire : assert property (
    @(posedge clk) disable iff (rst)
    (valid_o && next_ready_i) |-> commit_o.branch_retire == exp_head.branch_retire
  ) else begin
    errors++;
    $display("CHECK FAILED commit_o.branch_retire got %h expected %h",
             $sampled(commit_o.branch_retire), exp_head.branch_retire);
  end

  a_ebreak : assert property (
    @(posedge clk) disable iff (rst)
    (valid_o && next_ready_i) |-> commit_o.ebreak == exp_head.ebreak
  ) else begin
    errors++;
    $display("CHECK FAILED commit_o.ebreak got %h expected %h",
             $sampled(commit_o.ebreak), exp_head.ebreak);
  end

  function automatic logic [31:0] fill_word(input int idx);
    return 32'h9e37_79b9 * (idx + 1);
  endfunction

  function automatic logic [31:0] ref_alu(input logic [3:0] op, input logic [31:0] a,
                                          input logic [31:0] b);
    case (op)
      `EXU_ALU_ADD:  return a + b;
      `EXU_ALU_SUB:  return a - b;
      `EXU_ALU_AND:  return a & b;
      `EXU_ALU_OR:   return a | b;
      `EXU_ALU_XOR:  return a ^ b;
      `EXU_ALU_SLL:  return a << b[4:0];
      `EXU_ALU_SRL:  return a >> b[4:0];
      `EXU_ALU_SRA:  return $unsigned($signed(a) >>> b[4:0]);
      `EXU_ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      `EXU_ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
      `EXU_ALU_SLE:  return ($signed(a) <= $signed(b)) ? 32'd1 : 32'd0;
      `EXU_ALU_SLEU: return (a <= b) ? 32'd1 : 32'd0;
      default:       return 32'd0;
    endcase
  endfunction

  function automatic logic [31:0] csr_read(input logic [11:0] addr);
    case (addr)
      `EXU_CSR_MSTATUS: return sh_mstatus;
      `EXU_CSR_MTVEC:   return sh_mtvec;
      `EXU_CSR_MEPC:    return sh_mepc;
      `EXU_CSR_MCAUSE:  return sh_mcause;
      default:          return 32'd0;
    endcase
  endfunction

  task automatic csr_write(input logic [11:0] addr, input logic [31:0] val);
    case (addr)
      `EXU_CSR_MSTATUS: sh_mstatus = val;
      `EXU_CSR_MTVEC:   sh_mtvec   = val;
      `EXU_CSR_MEPC:    sh_mepc    = val;
      `EXU_CSR_MCAUSE:  sh_mcause  = val;
      default: ;
    endcase
  endtask

  function automatic exu_pkg::exu_issue_t new_ins(input logic [6:0] opcode);
    exu_pkg::exu_issue_t ins;
    ins        = '0;
    ins.opcode = opcode;
    ins.pc     = $urandom() & 32'hffff_fffc;
    ins.src1   = $urandom();
    ins.src2   = $urandom();
    ins.jbase  = $urandom();
    ins.imm    = $urandom_range(4095, 0);
    ins.ebreak = ($urandom_range(1, 0) != 0);
    return ins;
  endfunction

  function automatic exu_pkg::exu_commit_t expect_of(input exu_pkg::exu_issue_t ins);
    exu_pkg::exu_commit_t want;
    want               = '0;
    want.rd            = ins.rd;
    want.npc           = ins.jbase + ins.imm;
    want.branch_retire = (ins.opcode == `EXU_OP_SYSTEM) || (ins.opcode == `EXU_OP_BRANCH) ||
                         (ins.opcode == `EXU_OP_LOAD);
    want.ebreak        = ins.ebreak;
    return want;
  endfunction

  task automatic send(input exu_pkg::exu_issue_t ins, input exu_pkg::exu_commit_t want);
    @(negedge clk);
    issue_i      = ins;
    prev_valid_i = 1'b1;
    exp_q.push_back(want);
    issued++;
    #1;
    while (!ready_o) begin
      @(negedge clk);
      #1;
    end
    // taken on this edge
    @(posedge clk);
  endtask

  task automatic end_test(input string name);
    @(negedge clk);
    prev_valid_i = 1'b0;
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    if (commits - test_commits != issued - test_issued) begin
      errors++;
      $display("%s: %0d instructions issued but %0d commits seen", name,
               issued - test_issued, commits - test_commits);
    end
    tests_run++;
    $display("test %0d %s: %0d instructions, %0d errors", tests_run, name,
             issued - test_issued, errors - test_errors);
    test_issued  = issued;
    test_commits = commits;
    test_errors  = errors;
  endtask

  task automatic test_alu();
    exu_pkg::exu_issue_t  ins;
    exu_pkg::exu_commit_t want;
    for (int i = 0; i < 24; i++) begin
      ins        = new_ins(7'b0110011);
      ins.alu_op = exu_pkg::alu_op_e'($urandom_range(11, 0));
      ins.rd     = $urandom_range(15, 0);
      if ($urandom_range(3, 0) == 0) begin
        ins.src2 = ins.src1;
      end
      want       = expect_of(ins);
      want.wdata = (ins.rd == 0) ? 32'd0 : ref_alu(ins.alu_op, ins.src1, ins.src2);
      send(ins, want);
    end
  endtask

  task automatic test_branch();
    exu_pkg::exu_issue_t  ins;
    exu_pkg::exu_commit_t want;
    int                   k;
    logic [31:0]          res;
    for (int i = 0; i < 24; i++) begin
      if (i % 3 == 2) begin
        ins        = new_ins(($urandom_range(1, 0) != 0) ? `EXU_OP_JAL : `EXU_OP_JALR);
        ins.alu_op = exu_pkg::ALU_ADD;
        ins.src1   = ins.pc;
        ins.src2   = 32'd4;
        ins.rd     = $urandom_range(15, 0);
        want          = expect_of(ins);
        want.wdata    = (ins.rd == 0) ? 32'd0 : ins.pc + 32'd4;
        want.redirect = 1'b1;
      end else begin
        ins = new_ins(`EXU_OP_BRANCH);
        k   = $urandom_range(5, 0);
        // beq, bne, then the four compares
        if (k == 0) begin
          ins.alu_op = exu_pkg::ALU_SUB;
        end else if (k == 1) begin
          ins.alu_op = exu_pkg::ALU_XOR;
        end else begin
          ins.alu_op = exu_pkg::alu_op_e'(k + 6);
        end
        if ($urandom_range(2, 0) == 0) begin
          ins.src2 = ins.src1;
        end
        res           = ref_alu(ins.alu_op, ins.src1, ins.src2);
        want          = expect_of(ins);
        want.redirect = (k == 0) ? (res == 32'd0) : (res != 32'd0);
      end
      send(ins, want);
    end
  endtask

  task automatic csr_op(input logic [11:0] addr, input logic [2:0] f3, input logic [31:0] val,
                        input logic [3:0] rd);
    exu_pkg::exu_issue_t  ins;
    exu_pkg::exu_commit_t want;
    logic [31:0]          old;
    logic [31:0]          nxt;
    ins        = new_ins(`EXU_OP_SYSTEM);
    ins.func3  = f3;
    ins.imm    = {20'h0, addr};
    ins.src1   = val;
    ins.rd     = rd;
    ins.csr_op = 1'b1;
    old        = csr_read(addr);
    case (f3[1:0])
      2'b01:   nxt = val;
      2'b10:   nxt = old | val;
      default: nxt = old & ~val;
    endcase
    want       = expect_of(ins);
    want.wdata = (rd == 0) ? 32'd0 : old;
    csr_write(addr, nxt);
    send(ins, want);
  endtask

  task automatic sys_op(input logic [11:0] code);
    exu_pkg::exu_issue_t  ins;
    exu_pkg::exu_commit_t want;
    ins           = new_ins(`EXU_OP_SYSTEM);
    ins.sys_func  = 1'b1;
    ins.imm       = {20'h0, code};
    want          = expect_of(ins);
    want.redirect = 1'b1;
    if (code == `EXU_SYS_ECALL) begin
      want.npc  = sh_mtvec;
      sh_mepc   = ins.pc;
      sh_mcause = `EXU_CAUSE_ECALL_M;
    end else begin
      want.npc      = sh_mepc;
      sh_mstatus[7] = 1'b1;
    end
    send(ins, want);
  endtask

  task automatic test_csr();
    logic [11:0] addr;
    logic [2:0]  f3;
    for (int i = 0; i < 20; i++) begin
      case ($urandom_range(4, 0))
        0:       addr = `EXU_CSR_MSTATUS;
        1:       addr = `EXU_CSR_MTVEC;
        2:       addr = `EXU_CSR_MEPC;
        3:       addr = `EXU_CSR_MCAUSE;
        default: addr = 12'h7c0;
      endcase
      f3 = 3'($urandom_range(3, 1));
      if ($urandom_range(1, 0) != 0) begin
        f3[2] = 1'b1;
      end
      csr_op(addr, f3, $urandom(), 4'($urandom_range(15, 0)));
    end
  endtask

  task automatic test_trap();
    for (int i = 0; i < 4; i++) begin
      csr_op(`EXU_CSR_MTVEC, 3'b001, $urandom() & 32'hffff_fffc, 4'($urandom_range(15, 0)));
      csr_op(`EXU_CSR_MSTATUS, 3'b011, 32'h80, 4'd0);
      sys_op(`EXU_SYS_ECALL);
      csr_op(`EXU_CSR_MEPC, 3'b010, 32'd0, 4'd1);
      csr_op(`EXU_CSR_MCAUSE, 3'b010, 32'd0, 4'd2);
      sys_op(`EXU_SYS_MRET);
      csr_op(`EXU_CSR_MSTATUS, 3'b010, 32'd0, 4'd3);
    end
  endtask

  task automatic mem_op(input logic store, input logic [31:0] addr, input logic [31:0] data,
                        input logic [3:0] rd);
    exu_pkg::exu_issue_t  ins;
    exu_pkg::exu_commit_t want;
    ins       = new_ins(store ? `EXU_OP_STORE : `EXU_OP_LOAD);
    ins.imm   = $urandom_range(15, 0) << 2;
    ins.src1  = addr - ins.imm;
    ins.src2  = data;
    ins.rd    = rd;
    ins.store = store;
    ins.load  = !store;
    want      = expect_of(ins);
    if (store) begin
      ref_mem[addr[9:2]] = data;
    end else if (rd != 0) begin
      want.wdata = ref_mem[addr[9:2]];
    end
    send(ins, want);
  endtask

  task automatic test_mem();
    logic [31:0] addrs [12];
    int          k;
    for (int i = 0; i < 12; i++) begin
      addrs[i] = $urandom_range(255, 0) << 2;
      mem_op(1'b1, addrs[i], $urandom(), 4'd0);
    end
    for (int i = 0; i < 12; i++) begin
      k = $urandom_range(11, 0);
      mem_op(1'b0, addrs[k], 32'd0, 4'($urandom_range(15, 1)));
    end
    // likely never written, so the fill word comes back
    mem_op(1'b0, $urandom_range(255, 0) << 2, 32'd0, 4'd5);
  endtask

  initial begin
    repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
    $display("watchdog: run still going after %0d cycles", NUM_TESTS * CYCLES_PER_TEST);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    void'($urandom(32'hc1d1_4e38));
    rst          = 1'b1;
    issue_i      = '0;
    prev_valid_i = 1'b0;
    next_ready_i = 1'b0;
    mem_rdata_i  = '0;
    mem_rvalid_i = 1'b0;
    mem_wready_i = 1'b0;
    mem_busy     = 1'b0;
    mem_wait     = 0;
    exp_avail    = 1'b0;
    exp_head     = '0;
    issued       = 0;
    commits      = 0;
    errors       = 0;
    tests_run    = 0;
    test_issued  = 0;
    test_commits = 0;
    test_errors  = 0;
    sh_mstatus   = 32'd0;
    sh_mtvec     = `EXU_MTVEC_RESET;
    sh_mepc      = 32'd0;
    sh_mcause    = 32'd0;
    for (int i = 0; i < 256; i++) begin
      mem[i]     = fill_word(i);
      ref_mem[i] = fill_word(i);
    end
    repeat (16) @(negedge clk);
    rst = 1'b0;
    test_alu();
    end_test("alu");
    test_branch();
    end_test("branch and jump");
    test_csr();
    end_test("csr read-modify-write");
    test_trap();
    end_test("ecall and mret");
    test_mem();
    end_test("store and load");
    $display("tests %0d, instructions %0d, commits %0d, errors %0d", tests_run, issued,
             commits, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- flist.f
+incdir+source
source/exu_pkg.sv
source/exu_alu.sv
source/exu_csr_file.sv
source/exu_stage.sv
source/exu_top.sv
verification/exu_tb.sv

//--- Bender.yml
package:
  name: exu

sources:
  - include_dirs:
      - source
    files:
      - source/exu_pkg.sv
      - source/exu_alu.sv
      - source/exu_csr_file.sv
      - source/exu_stage.sv
      - source/exu_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - verification/exu_tb.sv
